/* common/mmioPkg.sv */
// ==========================================================
// MMIO client shared definitions
// ==========================================================
`default_nettype none

package mmioPkg;

  // Host bus geometry
  localparam int mmioDataWidth   = 8;
  localparam int mmioAddrWidth   = 8;
  localparam int mmioOffsetWidth = 7;  // One 128-byte half

  typedef logic [mmioDataWidth-1:0]   mmioData;
  typedef logic [mmioOffsetWidth-1:0] mmioOffset;

  // Decoded bus operation, one per sampled strobe
  typedef enum logic [2:0] {
    accIdle,
    accRegRead,
    accRegWrite,
    accPageRead,
    accPageWrite
  } mmioAccess;

  // Per-byte behaviour in the register half
  typedef enum logic [1:0] {
    rcNone,  // Reads 00
    rcRw,    // Stored, writable
    rcRo     // Status overlay
  } regClass;

  // ==========================================================
  // Register map
  // ==========================================================
  localparam mmioOffset cfgVpdId     = 7'h00;
  localparam mmioOffset cfgVpdVer    = 7'h01;
  localparam mmioOffset cfgVpdRev    = 7'h02;
  localparam mmioOffset phyStat      = 7'h10;  // Sync'd readiness and lock bits
  localparam mmioOffset phyCtrl      = 7'h11;
  localparam mmioOffset ly2Ctrl      = 7'h20;
  localparam mmioOffset ly2Mac0      = 7'h22;  // MAC MSB
  localparam mmioOffset ly2Mac1      = 7'h23;
  localparam mmioOffset ly2Mac2      = 7'h24;
  localparam mmioOffset ly2Mac3      = 7'h25;
  localparam mmioOffset ly2Mac4      = 7'h26;
  localparam mmioOffset ly2Mac5      = 7'h27;  // MAC LSB
  localparam mmioOffset ly3Ctrl0     = 7'h30;
  localparam mmioOffset ly3Ip0       = 7'h34;  // IP MSB
  localparam mmioOffset ly3Ip1       = 7'h35;
  localparam mmioOffset ly3Ip2       = 7'h36;
  localparam mmioOffset ly3Ip3       = 7'h37;  // IP LSB
  localparam mmioOffset diagScratch0 = 7'h70;
  localparam mmioOffset diagScratch1 = 7'h71;
  localparam mmioOffset diagScratch2 = 7'h72;
  localparam mmioOffset diagScratch3 = 7'h73;
  localparam mmioOffset diagLoopCtrl = 7'h74;
  localparam mmioOffset diagPageSel  = 7'h7F;  // Page shown in upper half

  // Byte class lookup
  function automatic regClass regClassOf(input mmioOffset off);
    regClass cls;
    case (off)
      cfgVpdId, cfgVpdVer, cfgVpdRev, phyCtrl, ly2Ctrl, ly3Ctrl0,
      ly2Mac0, ly2Mac1, ly2Mac2, ly2Mac3, ly2Mac4, ly2Mac5,
      ly3Ip0, ly3Ip1, ly3Ip2, ly3Ip3,
      diagScratch0, diagScratch1, diagScratch2, diagScratch3,
      diagLoopCtrl, diagPageSel: cls = rcRw;
      phyStat:                   cls = rcRo;
      default:                   cls = rcNone;  // Holes in the map
    endcase
    return cls;
  endfunction

  // Reset value of a byte, ID depends on privilege
  function automatic mmioData regDefault(input mmioOffset off, input bit priv);
    mmioData val;
    case (off)
      cfgVpdId:     val = priv ? 8'h3D : 8'h3C;
      cfgVpdVer:    val = 8'h01;
      phyCtrl:      val = 8'h01;  // Equalizer mode on
      diagScratch0: val = 8'hDE;
      diagScratch1: val = 8'hAD;
      diagScratch2: val = 8'hBE;
      diagScratch3: val = 8'hEF;
      default:      val = 8'h00;
    endcase
    return val;
  endfunction

endpackage : mmioPkg

`default_nettype wire

/* filelist.f */
+incdir+sim
common/mmioPkg.sv
rtl/mmioStatusSync.sv
rtl/mmioBusDecoder.sv
regFile/mmioRegFile.sv
pageRam/mmioPageRam.sv
rtl/mmioClient.sv
sim/tbMmioClient.sv

/* pageRam/mmioPageRam.sv */
// ==========================================================
// Paged byte memory
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module mmioPageRam #(
  parameter int pageRamBytes = 2048  // Multiple of 128
) (
  input  logic               shlClk,
  input  mmioPkg::mmioAccess access,
  input  mmioPkg::mmioOffset offset,
  input  mmioPkg::mmioData   pageSel,
  input  mmioPkg::mmioData   wrData,
  output mmioPkg::mmioData   pageRdData
);

  import mmioPkg::*;

  // Full memory address, page index on top of the window offset
  localparam int ramAddrWidth = $clog2(pageRamBytes);
  localparam int pageBits     = ramAddrWidth - mmioOffsetWidth;

  mmioData                 ram [pageRamBytes];  // No reset
  logic [ramAddrWidth-1:0] ramAddr;

  // Higher pages alias modulo the page count
  assign ramAddr = {pageSel[pageBits-1:0], offset};

  // ==========================================================
  // Single port, synchronous read
  // ==========================================================
  always_ff @(posedge shlClk)
  begin
    if (access == accPageWrite)
      ram[ramAddr] <= wrData;
  end

  always_ff @(posedge shlClk)
  begin
    if (access == accPageRead)
      pageRdData <= ram[ramAddr];  // Valid the next cycle
  end

endmodule : mmioPageRam

`default_nettype wire

/* regFile/mmioRegFile.sv */
// ==========================================================
// Control and status register file
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module mmioRegFile #(
  parameter bit superPriv = 1'b1
) (
  input  logic               shlClk,
  input  logic               rst,
  input  mmioPkg::mmioAccess access,
  input  mmioPkg::mmioOffset offset,
  input  mmioPkg::mmioData   wrData,
  input  logic [3:0]         statusSync,
  output mmioPkg::mmioData   regRdData,
  output mmioPkg::mmioData   pageSel,
  // Decoded controls
  output logic               eth0RxEqualizerMode,
  output logic               eth0PcsLoopbackEn,
  output logic               eth0MacLoopbackEn,
  output logic [47:0]        nts0MacAddress,
  output logic [31:0]        nts0IpAddress
);

  import mmioPkg::*;

  localparam int regCount = 2 ** mmioOffsetWidth;  // 128 bytes

  mmioData regs [regCount];  // Byte storage, flops
  regClass offsetClass;      // Class of the addressed byte

  assign offsetClass = regClassOf(offset);

  // ==========================================================
  // Storage with reset defaults
  // ==========================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      for (int i = 0; i < regCount; i++)
        regs[i] <= regDefault(mmioOffset'(i), superPriv);
    end
    else if (access == accRegWrite && offsetClass == rcRw)
    begin
      regs[offset] <= wrData;  // RO and unmapped bytes ignore writes
    end
  end

  // ==========================================================
  // Read port, one cycle
  // ==========================================================
  always_ff @(posedge shlClk)
  begin
    if (access == accRegRead)
    begin
      case (offsetClass)
        rcRw:    regRdData <= regs[offset];
        rcRo:    regRdData <= {4'b0000, statusSync};  // Upper nibble reads 0
        default: regRdData <= '0;
      endcase
    end
  end

  // ==========================================================
  // Control outputs
  // ==========================================================
  assign eth0RxEqualizerMode = regs[phyCtrl][0];
  assign eth0PcsLoopbackEn   = regs[diagLoopCtrl][0];
  assign eth0MacLoopbackEn   = regs[diagLoopCtrl][1];

  // MAC0 and IP0 are the most significant bytes
  assign nts0MacAddress = {regs[ly2Mac0], regs[ly2Mac1], regs[ly2Mac2],
                           regs[ly2Mac3], regs[ly2Mac4], regs[ly2Mac5]};
  assign nts0IpAddress  = {regs[ly3Ip0], regs[ly3Ip1], regs[ly3Ip2], regs[ly3Ip3]};

  assign pageSel = regs[diagPageSel];  // To the page window

endmodule : mmioRegFile

`default_nettype wire

/* rtl/mmioBusDecoder.sv */
// ==========================================================
// Host bus decoder
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module mmioBusDecoder (
  input  logic                              shlClk,
  input  logic                              rst,
  input  logic                              csN,
  input  logic                              weN,
  input  logic [mmioPkg::mmioAddrWidth-1:0] addr,
  input  mmioPkg::mmioData                  wrData,
  output mmioPkg::mmioAccess                access,
  output mmioPkg::mmioOffset                offset,
  input  mmioPkg::mmioData                  regRdData,
  input  mmioPkg::mmioData                  pageRdData,
  output mmioPkg::mmioData                  rdData,
  output logic                              rdValid
);

  import mmioPkg::*;

  logic    upperHalf;   // Address bit 7, page window
  logic    rdFromPage;  // Source of the read in flight

  assign upperHalf = addr[mmioAddrWidth-1];
  assign offset    = addr[mmioOffsetWidth-1:0];

  // ==========================================================
  // Strobe classification
  // ==========================================================
  always_comb
  begin
    access = accIdle;
    if (!csN)
    begin
      if (upperHalf)
        access = weN ? accPageRead : accPageWrite;
      else
        access = weN ? accRegRead : accRegWrite;
    end
  end

  // One registered stage on the read return
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      rdValid    <= 1'b0;
      rdFromPage <= 1'b0;
    end
    else
    begin
      rdValid    <= (access == accRegRead) || (access == accPageRead);
      rdFromPage <= (access == accPageRead);
    end
  end

  // Both sources already registered by their own blocks
  assign rdData = rdFromPage ? pageRdData : regRdData;

endmodule : mmioBusDecoder

`default_nettype wire

/* rtl/mmioClient.sv */
// ==========================================================
// MMIO client top level
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module mmioClient #(
  parameter bit superPriv    = 1'b1,  // Privileged ID, builds page memory
  parameter int pageRamBytes = 2048   // Multiple of 128
) (
  input  logic                              shlClk,
  input  logic                              rst,
  // Host bus
  input  logic                              csN,
  input  logic                              weN,
  input  logic [mmioPkg::mmioAddrWidth-1:0] addr,
  input  mmioPkg::mmioData                  wrData,
  output mmioPkg::mmioData                  rdData,
  output logic                              rdValid,
  // Asynchronous status
  input  logic                              mc0CalDone,
  input  logic                              mc1CalDone,
  input  logic                              eth0CoreReady,
  input  logic                              eth0QpllLock,
  // Control outputs
  output logic                              eth0RxEqualizerMode,
  output logic                              eth0PcsLoopbackEn,
  output logic                              eth0MacLoopbackEn,
  output logic [47:0]                       nts0MacAddress,
  output logic [31:0]                       nts0IpAddress
);

  import mmioPkg::*;

  mmioAccess  access;      // Decoded strobe
  mmioOffset  offset;      // Offset inside either half
  mmioData    regRdData;
  mmioData    pageRdData;
  mmioData    pageSel;
  logic [3:0] statusSync;

  // ==========================================================
  // Bus decode and read return
  // ==========================================================
  mmioBusDecoder uDecoder (
    .shlClk     (shlClk),
    .rst        (rst),
    .csN        (csN),
    .weN        (weN),
    .addr       (addr),
    .wrData     (wrData),
    .access     (access),
    .offset     (offset),
    .regRdData  (regRdData),
    .pageRdData (pageRdData),
    .rdData     (rdData),
    .rdValid    (rdValid)
  );

  // Bit order follows phyStat layout
  mmioStatusSync #(
    .width (4)
  ) uStatusSync (
    .shlClk (shlClk),
    .rst    (rst),
    .async  ({eth0QpllLock, eth0CoreReady, mc1CalDone, mc0CalDone}),
    .sync   (statusSync)
  );

  mmioRegFile #(
    .superPriv (superPriv)
  ) uRegFile (
    .shlClk              (shlClk),
    .rst                 (rst),
    .access              (access),
    .offset              (offset),
    .wrData              (wrData),
    .statusSync          (statusSync),
    .regRdData           (regRdData),
    .pageSel             (pageSel),
    .eth0RxEqualizerMode (eth0RxEqualizerMode),
    .eth0PcsLoopbackEn   (eth0PcsLoopbackEn),
    .eth0MacLoopbackEn   (eth0MacLoopbackEn),
    .nts0MacAddress      (nts0MacAddress),
    .nts0IpAddress       (nts0IpAddress)
  );

  // Page window only in the privileged build
  generate
    if (superPriv)
    begin : genPageRam
      mmioPageRam #(
        .pageRamBytes (pageRamBytes)
      ) uPageRam (
        .shlClk     (shlClk),
        .access     (access),
        .offset     (offset),
        .pageSel    (pageSel),
        .wrData     (wrData),
        .pageRdData (pageRdData)
      );
    end
    else
    begin : genNoPageRam
      assign pageRdData = '0;  // Window reads as zero
    end
  endgenerate

endmodule : mmioClient

`default_nettype wire

/* rtl/mmioStatusSync.sv */
// ==========================================================
// Status input synchronizer
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module mmioStatusSync #(
  parameter int width = 4
) (
  input  logic             shlClk,
  input  logic             rst,
  input  logic [width-1:0] async,  // From other clock domains
  output logic [width-1:0] sync
);

  logic [width-1:0] meta;  // First stage, may go metastable

  // ==========================================================
  // Two flops per bit
  // ==========================================================
  always_ff @(posedge shlClk)
  begin
    if (rst)
    begin
      meta <= '0;
      sync <= '0;
    end
    else
    begin
      meta <= async;
      sync <= meta;  // Settled copy
    end
  end

endmodule : mmioStatusSync

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the MMIO client testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tbMmioClient \
  -Mdir obj_dir -o simMmioClient || { echo "build error"; exit 1; }

simOut="$(./obj_dir/simMmioClient)"
echo "$simOut"

# Pass only when the pass line shows up on its own
echo "$simOut" | grep -qx "sim passed" && exit 0 || exit 1

/* sim/tbMmioTasks.svh */
// ==========================================================
// Bus tasks and directed tests
// ==========================================================
`ifndef tbMmioTasksSvh
`define tbMmioTasksSvh

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic mmioData randomByte();
    mmioData b;
    b = '0;
    for (int i = 0; i < 8; i++)
      b = {b[6:0], lfsrStep()};  // One step per bit
    return b;
  endfunction

  // ==========================================================
  // Host bus access
  // ==========================================================
  // Strobe held until the next task's first edge samples it
  task automatic busWrite(input logic [7:0] a, input mmioData d);
    @(posedge clk);
    csN    <= 1'b0;
    weN    <= 1'b0;
    addr   <= a;
    wrData <= d;
  endtask

  task automatic busIdle();
    @(posedge clk);
    csN <= 1'b1;
    weN <= 1'b1;
  endtask

  // Write, commit, then look at the outputs mid-cycle
  task automatic writeSettled(input logic [7:0] a, input mmioData d);
    busWrite(a, d);
    busIdle();
    @(negedge clk);
  endtask

  task automatic busRead(input logic [7:0] a, input mmioData exp);
    @(posedge clk);
    csN  <= 1'b0;
    weN  <= 1'b1;
    addr <= a;
    @(posedge clk);   // Read sampled here
    csN <= 1'b1;
    @(negedge clk);   // Return byte stable
    assert (rdValid === 1'b1)
    else
    begin
      errorCount++;
      $display("read of address %02h at %0t ns got no rdValid one cycle later", a, $time);
    end
    checkByte($sformatf("read %02h", a), rdData, exp);
  endtask

  // ==========================================================
  // Directed tests
  // ==========================================================
  task automatic testResetDefaults();
    int errsBefore;
    errsBefore = errorCount;
    repeat (3)
    begin
      @(negedge clk);
      checkFlag("rdValid before any read", rdValid, 1'b0);
    end
    checkFlag("eth0RxEqualizerMode", eth0RxEqualizerMode, 1'b1);  // phyCtrl default
    checkFlag("eth0PcsLoopbackEn", eth0PcsLoopbackEn, 1'b0);
    checkFlag("eth0MacLoopbackEn", eth0MacLoopbackEn, 1'b0);
    checkWide("nts0MacAddress", nts0MacAddress, 48'h0);
    checkWide("nts0IpAddress", {16'h0, nts0IpAddress}, 48'h0);
    busRead(8'h00, 8'h3D);  // Privileged ID
    busRead(8'h01, 8'h01);
    busRead(8'h02, 8'h00);
    busRead(8'h11, 8'h01);
    busRead(8'h70, 8'hDE);
    busRead(8'h71, 8'hAD);
    busRead(8'h72, 8'hBE);
    busRead(8'h73, 8'hEF);
    finishTest("reset defaults", errsBefore);
  endtask

  task automatic testAddressRegs();
    int      errsBefore;
    mmioData b;
    errsBefore = errorCount;
    for (int k = 0; k < 6; k++)
    begin
      b = randomByte();
      macExp[47-8*k -: 8] = b;  // Mac0 is the top byte
      busWrite(8'(8'h22 + k), b);
    end
    for (int k = 0; k < 4; k++)
    begin
      b = randomByte();
      ipExp[31-8*k -: 8] = b;
      busWrite(8'(8'h34 + k), b);
    end
    busIdle();
    @(negedge clk);
    checkWide("nts0MacAddress", nts0MacAddress, macExp);
    checkWide("nts0IpAddress", {16'h0, nts0IpAddress}, {16'h0, ipExp});
    for (int k = 0; k < 6; k++)
      busRead(8'(8'h22 + k), macExp[47-8*k -: 8]);
    for (int k = 0; k < 4; k++)
      busRead(8'(8'h34 + k), ipExp[31-8*k -: 8]);
    // Write then read on consecutive edges
    b = randomByte();
    macExp[23:16] = b;  // Mac3
    busWrite(8'h25, b);
    busRead(8'h25, b);
    checkWide("nts0MacAddress after Mac3 update", nts0MacAddress, macExp);
    finishTest("address registers", errsBefore);
  endtask

  task automatic testStatusClasses();
    int         errsBefore;
    logic [3:0] pattern;
    errsBefore = errorCount;
    pattern = 4'b1010;
    repeat (2)
    begin
      @(posedge clk);
      mc0CalDone    <= pattern[0];
      mc1CalDone    <= pattern[1];
      eth0CoreReady <= pattern[2];
      eth0QpllLock  <= pattern[3];
      repeat (3) @(posedge clk);  // Two sync stages plus one
      busRead(8'h10, {4'h0, pattern});
      busWrite(8'h10, 8'hFF);      // Status byte ignores writes
      busRead(8'h10, {4'h0, pattern});
      pattern = ~pattern;
    end
    busWrite(8'h50, 8'h5A);        // Hole in the map
    busRead(8'h50, 8'h00);
    finishTest("status and register classes", errsBefore);
  endtask

  task automatic testControlBits();
    int errsBefore;
    errsBefore = errorCount;
    writeSettled(8'h74, 8'h03);
    checkFlag("eth0PcsLoopbackEn", eth0PcsLoopbackEn, 1'b1);
    checkFlag("eth0MacLoopbackEn", eth0MacLoopbackEn, 1'b1);
    writeSettled(8'h74, 8'h00);
    checkFlag("eth0PcsLoopbackEn", eth0PcsLoopbackEn, 1'b0);
    checkFlag("eth0MacLoopbackEn", eth0MacLoopbackEn, 1'b0);
    writeSettled(8'h11, 8'h00);
    checkFlag("eth0RxEqualizerMode", eth0RxEqualizerMode, 1'b0);
    busRead(8'h11, 8'h00);
    finishTest("control bits", errsBefore);
  endtask

  // Pages under test
  function automatic mmioData pageOf(input int p);
    case (p)
      0:       return 8'd0;
      1:       return 8'd5;
      default: return 8'd15;  // Last of 16
    endcase
  endfunction

  // Window addresses, both ends and a few between
  function automatic logic [7:0] windowAddr(input int k);
    case (k)
      0:       return 8'h80;
      1:       return 8'h81;
      2:       return 8'hA5;
      3:       return 8'hC3;
      4:       return 8'hFE;
      default: return 8'hFF;
    endcase
  endfunction

  task automatic testPagedMemory();
    int      errsBefore;
    mmioData pageExp [3][6];
    errsBefore = errorCount;
    for (int p = 0; p < 3; p++)
    begin
      busWrite(8'h7F, pageOf(p));
      for (int k = 0; k < 6; k++)
      begin
        pageExp[p][k] = randomByte();
        busWrite(windowAddr(k), pageExp[p][k]);
      end
    end
    // Revisit each page and read back
    for (int p = 0; p < 3; p++)
    begin
      busWrite(8'h7F, pageOf(p));
      for (int k = 0; k < 6; k++)
        busRead(windowAddr(k), pageExp[p][k]);
    end
    busWrite(8'h7F, 8'h10);  // Page 16 wraps to page 0
    for (int k = 0; k < 6; k++)
      busRead(windowAddr(k), pageExp[0][k]);
    // Register half untouched by window traffic
    busRead(8'h7F, 8'h10);
    busRead(8'h70, 8'hDE);
    busRead(8'h71, 8'hAD);
    busRead(8'h72, 8'hBE);
    busRead(8'h73, 8'hEF);
    checkWide("nts0MacAddress", nts0MacAddress, macExp);
    checkWide("nts0IpAddress", {16'h0, nts0IpAddress}, {16'h0, ipExp});
    finishTest("paged memory", errsBefore);
  endtask

`endif

/* sim/tbMmioClient.sv */
// ==========================================================
// MMIO client testbench
// ==========================================================
`timescale 1ns/10ps
`default_nettype none

module tbMmioClient;

  import mmioPkg::*;

  localparam int timeoutCycles = 3000;  // Far above the whole sequence

  // DUT ports
  logic        clk;
  logic        rst;
  logic        csN;
  logic        weN;
  logic [7:0]  addr;
  mmioData     wrData;
  mmioData     rdData;
  logic        rdValid;
  logic        mc0CalDone;
  logic        mc1CalDone;
  logic        eth0CoreReady;
  logic        eth0QpllLock;
  logic        eth0RxEqualizerMode;
  logic        eth0PcsLoopbackEn;
  logic        eth0MacLoopbackEn;
  logic [47:0] nts0MacAddress;
  logic [31:0] nts0IpAddress;

  // Bookkeeping
  logic [31:0] lfsrState;    // Random byte source
  logic [47:0] macExp;       // Bytes last written to 22..27
  logic [31:0] ipExp;        // Bytes last written to 34..37
  int          errorCount;
  int          testsPassed;
  int          testsFailed;
  int          cycleCount;

  mmioClient #(
    .superPriv    (1'b1),
    .pageRamBytes (2048)    // 16 pages
  ) dut (
    .shlClk              (clk),
    .rst                 (rst),
    .csN                 (csN),
    .weN                 (weN),
    .addr                (addr),
    .wrData              (wrData),
    .rdData              (rdData),
    .rdValid             (rdValid),
    .mc0CalDone          (mc0CalDone),
    .mc1CalDone          (mc1CalDone),
    .eth0CoreReady       (eth0CoreReady),
    .eth0QpllLock        (eth0QpllLock),
    .eth0RxEqualizerMode (eth0RxEqualizerMode),
    .eth0PcsLoopbackEn   (eth0PcsLoopbackEn),
    .eth0MacLoopbackEn   (eth0MacLoopbackEn),
    .nts0MacAddress      (nts0MacAddress),
    .nts0IpAddress       (nts0IpAddress)
  );

  // ==========================================================
  // Checks and per-test reporting
  // ==========================================================
  task automatic checkByte(input string what, input mmioData got, input mmioData exp);
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s gave %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic checkWide(input string what, input logic [47:0] got, input logic [47:0] exp);
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s is %012h, expected %012h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic finishTest(input string name, input int errsBefore);
    if (errorCount == errsBefore)
    begin
      testsPassed++;
      $display("test %s: ok", name);
    end
    else
    begin
      testsFailed++;
      $display("test %s: %0d errors", name, errorCount - errsBefore);
    end
  endtask

  `include "tbMmioTasks.svh"

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("timeout: no end of the test sequence after %0d cycles", timeoutCycles);
      $display("sim failed");
      $finish;
    end
  end

  // ==========================================================
  // Test sequence
  // ==========================================================
  initial
  begin
    rst           <= 1'b1;
    csN           <= 1'b1;  // Bus idle
    weN           <= 1'b1;
    addr          <= 8'h00;
    wrData        <= 8'h00;
    mc0CalDone    <= 1'b0;
    mc1CalDone    <= 1'b0;
    eth0CoreReady <= 1'b0;
    eth0QpllLock  <= 1'b0;
    cycleCount    <= 0;
    lfsrState   = 32'ha922_e160;
    macExp      = '0;
    ipExp       = '0;
    errorCount  = 0;
    testsPassed = 0;
    testsFailed = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    testResetDefaults();
    testAddressRegs();
    testStatusClasses();
    testControlBits();
    testPagedMemory();
    $display("tests %0d ok, %0d failing, %0d check errors", testsPassed, testsFailed,
             errorCount);
    if (testsFailed == 0 && errorCount == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule : tbMmioClient

`default_nettype wire
